// ==== VideoTxCsrPkg.sv ====
// shared widths, register offsets and reset values
// bus access and read-back structs
// control structs for dma, display, overlays and scene fade

package VideoTxCsrPkg;

	//--------------------------------------------------
	// bus and field widths
	//--------------------------------------------------
	localparam int kBusWidth        = 32;
	localparam int kOffsetWidth     = 16;	// register offset, adrs 15:0
	localparam int kBlockWidth      = 8;	// block field, adrs 23:16
	localparam logic [kBlockWidth-1:0] kBlockMap = 8'h04;
	localparam int kWriteBit        = 30;

	localparam int kDmaAdrsWidth    = 19;
	localparam int kHposWidth       = 11;
	localparam int kVposWidth       = 11;
	localparam int kColorDepth      = 24;
	localparam int kSceneTimingWidth = 7;

	localparam int kRectCount       = 7;
	localparam int kRectStride      = 5;
	// field order inside one overlay
	localparam int kFldColor        = 0;
	localparam int kFldLeft         = 1;
	localparam int kFldRight        = 2;
	localparam int kFldTop          = 3;
	localparam int kFldUnder        = 4;

	//--------------------------------------------------
	// register map
	//--------------------------------------------------
	localparam logic [kOffsetWidth-1:0] kOfsDmaEnable   = 16'h0004;
	localparam logic [kOffsetWidth-1:0] kOfsDmaCycle    = 16'h0008;
	localparam logic [kOffsetWidth-1:0] kOfsDmaStart    = 16'h000C;
	localparam logic [kOffsetWidth-1:0] kOfsDmaEnd      = 16'h0010;
	localparam logic [kOffsetWidth-1:0] kOfsDmaAdd      = 16'h0014;
	localparam logic [kOffsetWidth-1:0] kOfsVsgRst      = 16'h0020;
	localparam logic [kOffsetWidth-1:0] kOfsVpgRst      = 16'h0099;
	localparam logic [kOffsetWidth-1:0] kOfsMapSize     = 16'h0100;
	localparam logic [kOffsetWidth-1:0] kOfsRectBase    = 16'h0200;
	localparam logic [kOffsetWidth-1:0] kOfsSceneColor  = 16'h0300;
	localparam logic [kOffsetWidth-1:0] kOfsSceneTiming = 16'h0301;
	localparam logic [kOffsetWidth-1:0] kOfsSceneCtrl   = 16'h0302;
	localparam logic [kOffsetWidth-1:0] kOfsSceneStatus = 16'h0303;
	localparam logic [kOffsetWidth-1:0] kOfsHpos        = 16'h0400;
	localparam logic [kOffsetWidth-1:0] kOfsVpos        = 16'h0401;

	// 480x272 panel in 16x16 tiles
	localparam logic [7:0] kMapXReset = 8'd30;
	localparam logic [7:0] kMapYReset = 8'd17;

	//--------------------------------------------------
	// structs
	//--------------------------------------------------
	typedef struct packed {
		logic                    write;
		logic [kOffsetWidth-1:0] offset;
		logic [kBusWidth-1:0]    data;
	} csrAccess_t;

	typedef struct packed {
		logic                 hit;
		logic [kBusWidth-1:0] word;
	} csrRead_t;

	typedef struct packed {
		logic                     enable;
		logic                     cycleEnable;
		logic [kDmaAdrsWidth-1:0] adrsStart;
		logic [kDmaAdrsWidth-1:0] adrsEnd;
		logic [kDmaAdrsWidth-1:0] adrsAdd;
	} dmaCtrl_t;

	typedef struct packed {
		logic       vsgRst;
		logic       vpgRst;
		logic [7:0] mapXSize;
		logic [7:0] mapYSize;
	} displayCtrl_t;

	typedef struct packed {
		logic        [kColorDepth-1:0] color;
		logic signed [kHposWidth:0]    left;
		logic signed [kHposWidth:0]    right;
		logic signed [kVposWidth:0]    top;
		logic signed [kVposWidth:0]    under;
	} rect_t;

	typedef rect_t [kRectCount-1:0] rectSet_t;

	typedef struct packed {
		logic [kColorDepth-1:0]       color;
		logic [kSceneTimingWidth-1:0] frameTiming;	// fade step rate in frames
		logic                         addEn;
		logic                         subEn;
		logic                         rst;
	} sceneCtrl_t;

endpackage

// ==== CsrBusPort.sv ====
// bus side of the csr block
// write strobe qualification and registered read mux

module CsrBusPort
	import VideoTxCsrPkg::*;
(
	input  logic                 iSCLK,
	input  logic [kBusWidth-1:0] sUsiAdrs,
	input  logic [kBusWidth-1:0] sUsiWd,
	output csrAccess_t           csrAccess,
	input  csrRead_t             dmaRead,
	input  csrRead_t             displayRead,
	input  csrRead_t             rectRead,
	input  csrRead_t             sceneRead,
	output logic [kBusWidth-1:0] sUsiRd
);

	logic blockHit;

	//--------------------------------------------------
	// write qualification
	//--------------------------------------------------
	assign blockHit = (sUsiAdrs[kOffsetWidth +: kBlockWidth] == kBlockMap);

	// offset goes out on reads too, banks decode it for read-back
	assign csrAccess = '{
		write:  sUsiAdrs[kWriteBit] & blockHit,
		offset: sUsiAdrs[kOffsetWidth-1:0],
		data:   sUsiWd
	};

	//--------------------------------------------------
	// read data, offset only, block field ignored
	//--------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (dmaRead.hit)
			sUsiRd <= dmaRead.word;
		else if (displayRead.hit)
			sUsiRd <= displayRead.word;
		else if (rectRead.hit)
			sUsiRd <= rectRead.word;
		else if (sceneRead.hit)
			sUsiRd <= sceneRead.word;
		else
			sUsiRd <= sUsiWd;	// unmapped, echo write data
	end

endmodule

// ==== DmaCtrlRegs.sv ====
// frame-buffer dma control registers
// enable, cycle mode, start/end/add address, reload on done

module DmaCtrlRegs
	import VideoTxCsrPkg::*;
(
	input  logic       iSCLK,
	input  logic       iSRST,
	input  csrAccess_t csrAccess,
	input  logic       dmaDone,
	output dmaCtrl_t   dmaCtrl,
	output csrRead_t   dmaRead
);

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			dmaCtrl.enable      <= 1'b0;
			dmaCtrl.cycleEnable <= 1'b0;
			dmaCtrl.adrsStart   <= '0;
			dmaCtrl.adrsEnd     <= '1;	// full buffer
			dmaCtrl.adrsAdd     <= '0;
		end
		else
		begin
			// done wins over a same-cycle enable write
			if (dmaDone)
				dmaCtrl.enable <= dmaCtrl.cycleEnable;
			else if (csrAccess.write && csrAccess.offset == kOfsDmaEnable)
				dmaCtrl.enable <= csrAccess.data[0];

			if (csrAccess.write)
			begin
				case (csrAccess.offset)
					kOfsDmaCycle: dmaCtrl.cycleEnable <= csrAccess.data[0];
					kOfsDmaStart: dmaCtrl.adrsStart <= csrAccess.data[kDmaAdrsWidth-1:0];
					kOfsDmaEnd:   dmaCtrl.adrsEnd   <= csrAccess.data[kDmaAdrsWidth-1:0];
					kOfsDmaAdd:   dmaCtrl.adrsAdd   <= csrAccess.data[kDmaAdrsWidth-1:0];
					default:      ;
				endcase
			end
		end
	end

	// read-back
	always_comb
	begin
		dmaRead.hit  = 1'b1;
		dmaRead.word = '0;
		case (csrAccess.offset)
			kOfsDmaEnable: dmaRead.word = kBusWidth'(dmaCtrl.enable);
			kOfsDmaCycle:  dmaRead.word = kBusWidth'(dmaCtrl.cycleEnable);
			kOfsDmaStart:  dmaRead.word = kBusWidth'(dmaCtrl.adrsStart);
			kOfsDmaEnd:    dmaRead.word = kBusWidth'(dmaCtrl.adrsEnd);
			kOfsDmaAdd:    dmaRead.word = kBusWidth'(dmaCtrl.adrsAdd);
			default:       dmaRead.hit  = 1'b0;
		endcase
	end

endmodule

// ==== DisplayCtrlRegs.sv ====
// display control registers
// sync and pattern unit resets, tile map size, pixel position read-back

module DisplayCtrlRegs
	import VideoTxCsrPkg::*;
(
	input  logic                  iSCLK,
	input  logic                  iSRST,
	input  csrAccess_t            csrAccess,
	input  logic [kHposWidth-1:0] pdpHpos,
	input  logic [kVposWidth-1:0] pdpVpos,
	output displayCtrl_t          displayCtrl,
	output csrRead_t              displayRead
);

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			displayCtrl.vsgRst   <= 1'b1;	// sync gen held in reset
			displayCtrl.vpgRst   <= 1'b0;
			displayCtrl.mapXSize <= kMapXReset;
			displayCtrl.mapYSize <= kMapYReset;
		end
		else if (csrAccess.write)
		begin
			case (csrAccess.offset)
				kOfsVsgRst: displayCtrl.vsgRst <= csrAccess.data[0];
				kOfsVpgRst: displayCtrl.vpgRst <= csrAccess.data[0];
				kOfsMapSize:
				begin
					displayCtrl.mapXSize <= csrAccess.data[15:8];
					displayCtrl.mapYSize <= csrAccess.data[7:0];
				end
				default: ;
			endcase
		end
	end

	//--------------------------------------------------
	// read-back, position is live from the pixel pipe
	//--------------------------------------------------
	always_comb
	begin
		displayRead.hit  = 1'b1;
		displayRead.word = '0;
		case (csrAccess.offset)
			kOfsVsgRst:  displayRead.word = kBusWidth'(displayCtrl.vsgRst);
			kOfsVpgRst:  displayRead.word = kBusWidth'(displayCtrl.vpgRst);
			kOfsMapSize: displayRead.word = kBusWidth'({displayCtrl.mapXSize,
				displayCtrl.mapYSize});
			kOfsHpos:    displayRead.word = kBusWidth'(pdpHpos);
			kOfsVpos:    displayRead.word = kBusWidth'(pdpVpos);
			default:     displayRead.hit  = 1'b0;
		endcase
	end

endmodule

// ==== RectOverlayRegs.sv ====
// solid colour rectangle overlay registers
// colour and four edges per overlay, kRectCount overlays
// overlay n field f lives at base + n*stride + f

module RectOverlayRegs
	import VideoTxCsrPkg::*;
(
	input  logic       iSCLK,
	input  logic       iSRST,
	input  csrAccess_t csrAccess,
	output rectSet_t   rectSet,
	output csrRead_t   rectRead
);

	function automatic logic [kOffsetWidth-1:0] rectOfs(input int n, input int f);
		return kOffsetWidth'(kOfsRectBase + n * kRectStride + f);
	endfunction

	//--------------------------------------------------
	// write
	//--------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			rectSet <= '0;
		else if (csrAccess.write)
		begin
			for (int n = 0; n < kRectCount; n++)
			begin
				if (csrAccess.offset == rectOfs(n, kFldColor))
					rectSet[n].color <= csrAccess.data[kColorDepth-1:0];
				if (csrAccess.offset == rectOfs(n, kFldLeft))
					rectSet[n].left <= csrAccess.data[kHposWidth:0];	// low bits, signed
				if (csrAccess.offset == rectOfs(n, kFldRight))
					rectSet[n].right <= csrAccess.data[kHposWidth:0];
				if (csrAccess.offset == rectOfs(n, kFldTop))
					rectSet[n].top <= csrAccess.data[kVposWidth:0];
				if (csrAccess.offset == rectOfs(n, kFldUnder))
					rectSet[n].under <= csrAccess.data[kVposWidth:0];
			end
		end
	end

	//--------------------------------------------------
	// read-back
	//--------------------------------------------------
	// edges read back zero-extended, not sign-extended
	always_comb
	begin
		rectRead.hit  = 1'b0;
		rectRead.word = '0;
		for (int n = 0; n < kRectCount; n++)
		begin
			if (csrAccess.offset == rectOfs(n, kFldColor))
			begin
				rectRead.hit  = 1'b1;
				rectRead.word = kBusWidth'(rectSet[n].color);
			end
			if (csrAccess.offset == rectOfs(n, kFldLeft))
			begin
				rectRead.hit  = 1'b1;
				rectRead.word = kBusWidth'($unsigned(rectSet[n].left));
			end
			if (csrAccess.offset == rectOfs(n, kFldRight))
			begin
				rectRead.hit  = 1'b1;
				rectRead.word = kBusWidth'($unsigned(rectSet[n].right));
			end
			if (csrAccess.offset == rectOfs(n, kFldTop))
			begin
				rectRead.hit  = 1'b1;
				rectRead.word = kBusWidth'($unsigned(rectSet[n].top));
			end
			if (csrAccess.offset == rectOfs(n, kFldUnder))
			begin
				rectRead.hit  = 1'b1;
				rectRead.word = kBusWidth'($unsigned(rectSet[n].under));
			end
		end
	end

endmodule

// ==== SceneFadeRegs.sv ====
// scene fade registers
// fade colour, frame timing, add/sub/rst control, alpha limit status

module SceneFadeRegs
	import VideoTxCsrPkg::*;
(
	input  logic       iSCLK,
	input  logic       iSRST,
	input  csrAccess_t csrAccess,
	input  logic       sceneAlphaMax,
	input  logic       sceneAlphaMin,
	output sceneCtrl_t sceneCtrl,
	output csrRead_t   sceneRead
);

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			sceneCtrl.color       <= '0;
			sceneCtrl.frameTiming <= '0;
			sceneCtrl.addEn       <= 1'b0;
			sceneCtrl.subEn       <= 1'b0;
			sceneCtrl.rst         <= 1'b1;	// fade unit starts in reset
		end
		else if (csrAccess.write)
		begin
			case (csrAccess.offset)
				kOfsSceneColor:  sceneCtrl.color <= csrAccess.data[kColorDepth-1:0];
				kOfsSceneTiming:
					sceneCtrl.frameTiming <= csrAccess.data[kSceneTimingWidth-1:0];
				kOfsSceneCtrl:
				begin
					sceneCtrl.addEn <= csrAccess.data[0];
					sceneCtrl.subEn <= csrAccess.data[1];
					sceneCtrl.rst   <= csrAccess.data[2];
				end
				default: ;
			endcase
		end
	end

	//--------------------------------------------------
	// read-back
	//--------------------------------------------------
	always_comb
	begin
		sceneRead.hit  = 1'b1;
		sceneRead.word = '0;
		case (csrAccess.offset)
			kOfsSceneColor:  sceneRead.word = kBusWidth'(sceneCtrl.color);
			kOfsSceneTiming: sceneRead.word = kBusWidth'(sceneCtrl.frameTiming);
			kOfsSceneCtrl:
				sceneRead.word = kBusWidth'({sceneCtrl.rst, sceneCtrl.subEn, sceneCtrl.addEn});
			// live status from the fade unit
			kOfsSceneStatus: sceneRead.word = kBusWidth'({sceneAlphaMax, sceneAlphaMin});
			default:         sceneRead.hit  = 1'b0;
		endcase
	end

endmodule

// ==== VideoTxCsrTop.sv ====
// csr block top for the video transmit path
// bus port plus dma, display, overlay and scene register banks

module VideoTxCsrTop
	import VideoTxCsrPkg::*;
(
	input  logic                  iSCLK,
	input  logic                  iSRST,
	// bus
	input  logic [kBusWidth-1:0]  sUsiAdrs,
	input  logic [kBusWidth-1:0]  sUsiWd,
	output logic [kBusWidth-1:0]  sUsiRd,
	// dma
	input  logic                  dmaDone,
	output dmaCtrl_t              dmaCtrl,
	// display
	output displayCtrl_t          displayCtrl,
	input  logic [kHposWidth-1:0] pdpHpos,
	input  logic [kVposWidth-1:0] pdpVpos,
	// overlays
	output rectSet_t              rectSet,
	// scene fade
	output sceneCtrl_t            sceneCtrl,
	input  logic                  sceneAlphaMax,
	input  logic                  sceneAlphaMin
);

	csrAccess_t csrAccess;
	csrRead_t   dmaRead;
	csrRead_t   displayRead;
	csrRead_t   rectRead;
	csrRead_t   sceneRead;

	CsrBusPort u_busPort (
		.iSCLK       (iSCLK),
		.sUsiAdrs    (sUsiAdrs),
		.sUsiWd      (sUsiWd),
		.csrAccess   (csrAccess),
		.dmaRead     (dmaRead),
		.displayRead (displayRead),
		.rectRead    (rectRead),
		.sceneRead   (sceneRead),
		.sUsiRd      (sUsiRd)
	);

	DmaCtrlRegs u_dmaRegs (
		.iSCLK     (iSCLK),
		.iSRST     (iSRST),
		.csrAccess (csrAccess),
		.dmaDone   (dmaDone),
		.dmaCtrl   (dmaCtrl),
		.dmaRead   (dmaRead)
	);

	DisplayCtrlRegs u_displayRegs (
		.iSCLK       (iSCLK),
		.iSRST       (iSRST),
		.csrAccess   (csrAccess),
		.pdpHpos     (pdpHpos),
		.pdpVpos     (pdpVpos),
		.displayCtrl (displayCtrl),
		.displayRead (displayRead)
	);

	RectOverlayRegs u_rectRegs (
		.iSCLK     (iSCLK),
		.iSRST     (iSRST),
		.csrAccess (csrAccess),
		.rectSet   (rectSet),
		.rectRead  (rectRead)
	);

	SceneFadeRegs u_sceneRegs (
		.iSCLK         (iSCLK),
		.iSRST         (iSRST),
		.csrAccess     (csrAccess),
		.sceneAlphaMax (sceneAlphaMax),
		.sceneAlphaMin (sceneAlphaMin),
		.sceneCtrl     (sceneCtrl),
		.sceneRead     (sceneRead)
	);

endmodule

// ==== VideoTxCsrTbTasks.svh ====
// bus cycle, write and read tasks, result bookkeeping
// directed tests: reset, read-back, write qualification, dma reload, status

`ifndef VIDEO_TX_CSR_TB_TASKS_SVH
`define VIDEO_TX_CSR_TB_TASKS_SVH

task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
	$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
	testErrors++;
endtask

task automatic endTest(input string name);
	$display("%-20s %s, %0d errors", name, (testErrors == 0) ? "ok" : "failed", testErrors);
	testCount++;
	if (testErrors != 0)
		failedTests++;
	errorCount += testErrors;
	testErrors = 0;
endtask

// one bus cycle, called and left at 1 ns after a rising edge
task automatic busCycle(input logic [31:0] adrs, input logic [31:0] wd);
	sUsiAdrs = adrs;
	sUsiWd = wd;
	@(posedge iSCLK);
	#1;
	sUsiAdrs = '0;
	sUsiWd = '0;
endtask

task automatic busWrite(input logic [15:0] ofs, input logic [31:0] data);
	busCycle({8'h40, kBlockMap, ofs}, data);	// bit 30 plus our block
endtask

task automatic busRead(input logic [31:0] adrs, input logic [31:0] wd, output logic [31:0] rd);
	busCycle(adrs, wd);
	rd = sUsiRd;
endtask

task automatic waitResetDone(output logic ok);
	int cycles;
	cycles = 0;
	while (!(displayCtrl.vsgRst === 1'b1 && sceneCtrl.rst === 1'b1) && cycles < 16)
	begin
		@(posedge iSCLK);
		#1;
		cycles++;
	end
	ok = (displayCtrl.vsgRst === 1'b1 && sceneCtrl.rst === 1'b1);
endtask

task automatic expectReg(input logic [15:0] ofs, input logic [31:0] exp);
	logic [31:0] rd;
	if (outputOf(ofs) !== exp)
		mismatch(outputName(ofs), exp, outputOf(ofs));
	busRead({16'h0, ofs}, 32'h0, rd);
	if (rd !== exp)
		mismatch($sformatf("sUsiRd at %h", ofs), exp, rd);
endtask

task automatic expectRect(input int n, input int f, input logic [31:0] exp);
	logic [31:0] rd;
	if (rectOutput(n, f) !== exp)
		mismatch($sformatf("rectSet[%0d].%s", n, fieldName[f]), exp, rectOutput(n, f));
	busRead({16'h0, rectOffset(n, f)}, 32'h0, rd);
	if (rd !== exp)
		mismatch($sformatf("sUsiRd at %h", rectOffset(n, f)), exp, rd);
endtask

//--------------------------------------------------
// directed tests
//--------------------------------------------------
task automatic testResetDefaults();
	expectReg(kOfsDmaEnable, 32'h0);
	expectReg(kOfsDmaCycle, 32'h0);
	expectReg(kOfsDmaStart, 32'h0);
	expectReg(kOfsDmaEnd, 32'h0007_FFFF);	// end address all ones
	expectReg(kOfsDmaAdd, 32'h0);
	expectReg(kOfsVsgRst, 32'h1);
	expectReg(kOfsVpgRst, 32'h0);
	expectReg(kOfsMapSize, {16'h0, 8'd30, 8'd17});
	expectReg(kOfsSceneColor, 32'h0);
	expectReg(kOfsSceneTiming, 32'h0);
	expectReg(kOfsSceneCtrl, 32'h4);	// only rst set
	for (int n = 0; n < kRectCount; n++)
		for (int f = 0; f < kRectStride; f++)
			expectRect(n, f, 32'h0);
	endTest("reset defaults");
endtask

task automatic testWriteReadback();
	logic [31:0] d;
	logic [31:0] rectModel [kRectCount][kRectStride];
	foreach (ctrlOfs[i])
	begin
		d = $random(seed);
		if (((d ^ outputOf(ctrlOfs[i])) & regMask(ctrlOfs[i])) == 0)
			d = ~d;	// register must change
		busWrite(ctrlOfs[i], d);
		expectReg(ctrlOfs[i], d & regMask(ctrlOfs[i]));
	end
	d = $random(seed);
	if (((d ^ outputOf(kOfsSceneCtrl)) & regMask(kOfsSceneCtrl)) == 0)
		d = ~d;
	busWrite(kOfsSceneCtrl, d);
	expectReg(kOfsSceneCtrl, d & regMask(kOfsSceneCtrl));
	for (int n = 0; n < kRectCount; n++)
		for (int f = 0; f < kRectStride; f++)
			rectModel[n][f] = 32'h0;
	for (int n = 0; n < kRectCount; n++)
		for (int f = 0; f < kRectStride; f++)
		begin
			d = $random(seed);
			busWrite(rectOffset(n, f), d);
			rectModel[n][f] = d & rectMask(f);
			expectRect(n, f, rectModel[n][f]);
			// other overlays and fields keep their values
			for (int m = 0; m < kRectCount; m++)
				for (int g = 0; g < kRectStride; g++)
					if (rectOutput(m, g) !== rectModel[m][g])
						mismatch($sformatf("rectSet[%0d].%s", m, fieldName[g]),
							rectModel[m][g], rectOutput(m, g));
		end
	endTest("write and read-back");
endtask

task automatic testWriteQualify();
	logic [31:0] d;
	logic [31:0] rd;
	logic [15:0] ofs;
	for (int i = 0; i < 2; i++)
	begin
		ofs = (i == 0) ? kOfsDmaStart : kOfsSceneColor;
		d = $random(seed) & regMask(ofs);
		busWrite(ofs, d);
		busCycle({8'h00, kBlockMap, ofs}, ~d);	// write bit clear
		if (outputOf(ofs) !== d)
			mismatch(outputName(ofs), d, outputOf(ofs));
		busCycle({8'h40, kBlockMap ^ 8'h01, ofs}, ~d);	// wrong block
		if (outputOf(ofs) !== d)
			mismatch(outputName(ofs), d, outputOf(ofs));
		busRead({8'h00, 8'h5A, ofs}, ~d, rd);
		if (rd !== d)
			mismatch($sformatf("sUsiRd at %h", ofs), d, rd);
	end
	endTest("write qualification");
endtask

task automatic testDmaDoneReload();
	logic cyc;
	for (int i = 0; i < 2; i++)
	begin
		cyc = (i == 0);
		busWrite(kOfsDmaCycle, {31'h0, cyc});
		busWrite(kOfsDmaEnable, {31'h0, ~cyc});
		if (dmaCtrl.enable !== ~cyc)
			mismatch("dmaCtrl.enable", {31'h0, ~cyc}, {31'h0, dmaCtrl.enable});
		dmaDone = 1'b1;
		busCycle(32'h0, 32'h0);
		dmaDone = 1'b0;
		if (dmaCtrl.enable !== cyc)
			mismatch("dmaCtrl.enable", {31'h0, cyc}, {31'h0, dmaCtrl.enable});
		busWrite(kOfsDmaEnable, {31'h0, ~cyc});
		// done and an opposite enable write in the same cycle
		dmaDone = 1'b1;
		busWrite(kOfsDmaEnable, {31'h0, ~cyc});
		dmaDone = 1'b0;
		if (dmaCtrl.enable !== cyc)
			mismatch("dmaCtrl.enable", {31'h0, cyc}, {31'h0, dmaCtrl.enable});
	end
	endTest("dma done reload");
endtask

task automatic testLiveStatus();
	logic [31:0] d;
	logic [31:0] rd;
	logic [15:0] freeOfs [6];
	freeOfs = '{16'h0000, 16'h0098, 16'h0223, 16'h0304, 16'h0402, 16'hFFFF};
	for (int i = 0; i < 4; i++)
	begin
		d = $random(seed);
		d[1:0] = 2'(i);	// every alpha flag combination
		sceneAlphaMax = d[1];
		sceneAlphaMin = d[0];
		pdpHpos = d[26:16];
		pdpVpos = d[13:3];
		busRead({16'h0, kOfsSceneStatus}, 32'h0, rd);
		if (rd !== {30'h0, d[1], d[0]})
			mismatch("sUsiRd at 0303", {30'h0, d[1], d[0]}, rd);
		busRead({16'h0, kOfsHpos}, 32'h0, rd);
		if (rd !== {21'h0, d[26:16]})
			mismatch("sUsiRd at 0400", {21'h0, d[26:16]}, rd);
		busRead({16'h0, kOfsVpos}, 32'h0, rd);
		if (rd !== {21'h0, d[13:3]})
			mismatch("sUsiRd at 0401", {21'h0, d[13:3]}, rd);
	end
	foreach (freeOfs[i])
	begin
		d = $random(seed);
		busRead({16'h0, freeOfs[i]}, d, rd);	// unmapped echoes write data
		if (rd !== d)
			mismatch($sformatf("sUsiRd at %h", freeOfs[i]), d, rd);
	end
	endTest("live status");
endtask

`endif

// ==== VideoTxCsrTb.sv ====
// testbench top for the video tx csr block
// clock, reset, dut instance, register maps and result summary

module VideoTxCsrTb
	import VideoTxCsrPkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	logic                  iSCLK;
	logic                  iSRST;
	logic [kBusWidth-1:0]  sUsiAdrs;
	logic [kBusWidth-1:0]  sUsiWd;
	logic [kBusWidth-1:0]  sUsiRd;
	logic                  dmaDone;
	dmaCtrl_t              dmaCtrl;
	displayCtrl_t          displayCtrl;
	logic [kHposWidth-1:0] pdpHpos;
	logic [kVposWidth-1:0] pdpVpos;
	rectSet_t              rectSet;
	sceneCtrl_t            sceneCtrl;
	logic                  sceneAlphaMax;
	logic                  sceneAlphaMin;

	integer seed = 32'h2aab027f;
	int     testErrors = 0;
	int     errorCount = 0;
	int     testCount = 0;
	int     failedTests = 0;

	// every single-field control register outside the overlays
	logic [15:0] ctrlOfs [10] = '{kOfsDmaEnable, kOfsDmaCycle, kOfsDmaStart, kOfsDmaEnd,
		kOfsDmaAdd, kOfsVsgRst, kOfsVpgRst, kOfsMapSize, kOfsSceneColor, kOfsSceneTiming};
	string fieldName [5] = '{"color", "left", "right", "top", "under"};

	VideoTxCsrTop u_dut (
		.iSCLK         (iSCLK),
		.iSRST         (iSRST),
		.sUsiAdrs      (sUsiAdrs),
		.sUsiWd        (sUsiWd),
		.sUsiRd        (sUsiRd),
		.dmaDone       (dmaDone),
		.dmaCtrl       (dmaCtrl),
		.displayCtrl   (displayCtrl),
		.pdpHpos       (pdpHpos),
		.pdpVpos       (pdpVpos),
		.rectSet       (rectSet),
		.sceneCtrl     (sceneCtrl),
		.sceneAlphaMax (sceneAlphaMax),
		.sceneAlphaMin (sceneAlphaMin)
	);

	initial
	begin
		iSCLK = 1'b0;
		forever #50 iSCLK = ~iSCLK;	// 100 ns period
	end

	//--------------------------------------------------
	// expected register widths and output views
	//--------------------------------------------------
	function automatic logic [31:0] regMask(input logic [15:0] ofs);
		case (ofs)
			kOfsDmaStart, kOfsDmaEnd, kOfsDmaAdd: return 32'h0007_FFFF;
			kOfsMapSize:     return 32'h0000_FFFF;
			kOfsSceneColor:  return 32'h00FF_FFFF;
			kOfsSceneTiming: return 32'h0000_007F;
			kOfsSceneCtrl:   return 32'h0000_0007;
			default:         return 32'h0000_0001;	// single-bit controls
		endcase
	endfunction

	function automatic logic [31:0] outputOf(input logic [15:0] ofs);
		case (ofs)
			kOfsDmaEnable:   return {31'h0, dmaCtrl.enable};
			kOfsDmaCycle:    return {31'h0, dmaCtrl.cycleEnable};
			kOfsDmaStart:    return {13'h0, dmaCtrl.adrsStart};
			kOfsDmaEnd:      return {13'h0, dmaCtrl.adrsEnd};
			kOfsDmaAdd:      return {13'h0, dmaCtrl.adrsAdd};
			kOfsVsgRst:      return {31'h0, displayCtrl.vsgRst};
			kOfsVpgRst:      return {31'h0, displayCtrl.vpgRst};
			kOfsMapSize:     return {16'h0, displayCtrl.mapXSize, displayCtrl.mapYSize};
			kOfsSceneColor:  return {8'h0, sceneCtrl.color};
			kOfsSceneTiming: return {25'h0, sceneCtrl.frameTiming};
			kOfsSceneCtrl:   return {29'h0, sceneCtrl.rst, sceneCtrl.subEn, sceneCtrl.addEn};
			default:         return 32'h0;
		endcase
	endfunction

	function automatic string outputName(input logic [15:0] ofs);
		case (ofs)
			kOfsDmaEnable:   return "dmaCtrl.enable";
			kOfsDmaCycle:    return "dmaCtrl.cycleEnable";
			kOfsDmaStart:    return "dmaCtrl.adrsStart";
			kOfsDmaEnd:      return "dmaCtrl.adrsEnd";
			kOfsDmaAdd:      return "dmaCtrl.adrsAdd";
			kOfsVsgRst:      return "displayCtrl.vsgRst";
			kOfsVpgRst:      return "displayCtrl.vpgRst";
			kOfsMapSize:     return "displayCtrl.{mapXSize,mapYSize}";
			kOfsSceneColor:  return "sceneCtrl.color";
			kOfsSceneTiming: return "sceneCtrl.frameTiming";
			kOfsSceneCtrl:   return "sceneCtrl.{rst,subEn,addEn}";
			default:         return "unknown output";
		endcase
	endfunction

	function automatic logic [15:0] rectOffset(input int n, input int f);
		return kOfsRectBase + 16'(n * kRectStride + f);
	endfunction

	function automatic logic [31:0] rectMask(input int f);
		return (f == kFldColor) ? 32'h00FF_FFFF : 32'h0000_0FFF;
	endfunction

	function automatic logic [31:0] rectOutput(input int n, input int f);
		case (f)
			kFldColor: return {8'h0, rectSet[n].color};
			kFldLeft:  return {20'h0, rectSet[n].left};	// concat keeps it unsigned
			kFldRight: return {20'h0, rectSet[n].right};
			kFldTop:   return {20'h0, rectSet[n].top};
			kFldUnder: return {20'h0, rectSet[n].under};
			default:   return 32'h0;
		endcase
	endfunction

	`include "VideoTxCsrTbTasks.svh"

	//--------------------------------------------------
	// test sequence
	//--------------------------------------------------
	initial
	begin
		logic resetOk;
		iSRST = 1'b1;
		sUsiAdrs = '0;
		sUsiWd = '0;
		dmaDone = 1'b0;
		pdpHpos = '0;
		pdpVpos = '0;
		sceneAlphaMax = 1'b0;
		sceneAlphaMin = 1'b0;
		repeat (10) @(posedge iSCLK);
		#1;
		iSRST = 1'b0;
		waitResetDone(resetOk);
		if (!resetOk)
		begin
			$display("timeout: reset values never showed up on the DUT outputs");
			errorCount++;
		end
		else
		begin
			testResetDefaults();
			testWriteReadback();
			testWriteQualify();
			testDmaDoneReload();
			testLiveStatus();
		end
		$display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== VideoTxCsr.f ====
+incdir+.
VideoTxCsrPkg.sv
CsrBusPort.sv
DmaCtrlRegs.sv
DisplayCtrlRegs.sv
RectOverlayRegs.sv
SceneFadeRegs.sv
VideoTxCsrTop.sv
VideoTxCsrTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the csr testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
	-f VideoTxCsr.f --top-module VideoTxCsrTb -o VideoTxCsrSim
./obj_dir/VideoTxCsrSim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation reported failure, see sim.log"
	exit 1
fi
echo "simulation finished without failure"
